// File: source/MemoryBurstPkg.sv
// Memory burst port definitions
// Word, line and address widths plus the burst cycle numbers of the
// internal SDRAM model, shared by every block of the burst port.

package MemoryBurstPkg;

    // data and address widths
    localparam int WordWidth     = 32;
    localparam int LineWords     = 8;                 // also the burst length
    localparam int BankWidth     = 3;                 // log2 of LineWords
    localparam int WordAddrWidth = 10;
    localparam int LineAddrWidth = WordAddrWidth - BankWidth;

    // sdram sequencer counter width
    localparam int SdramCycleWidth = 4;

    // read burst, counted from the ack cycle
    localparam int SdramReadStartCycle   = 2;         // bank 0 address issued
    localparam int SdramReadEnableCycle  = 3;         // first data beat
    localparam int SdramReadDisableCycle = 11;        // first cycle past the window
    localparam int SdramReadEndCycle     = 12;

    // write burst, counted from the ack cycle
    localparam int SdramWriteEnableCycle  = 0;        // first data request
    localparam int SdramWriteStartCycle   = 1;        // bank 0 written
    localparam int SdramWriteDisableCycle = 8;
    localparam int SdramWriteEndCycle     = 9;

    typedef logic [WordWidth-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [LineWords-1:0] line_t;

    typedef logic [LineAddrWidth-1:0] lineAddr_t;
    typedef logic [WordAddrWidth-1:0] wordAddr_t;

endpackage

// File: source/BurstRequestArbiter.sv
// Burst request arbiter
// Takes line read and write requests while idle, keeps their addresses
// and drives the SDRAM request levels. A read always runs before a write
// that was taken in the same cycle.

`timescale 1ns/10ps

module BurstRequestArbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      readLineReq,
    input  MemoryBurstPkg::lineAddr_t readLineAddr,
    input  logic                      writeLineReq,
    input  MemoryBurstPkg::lineAddr_t writeLineAddr,
    input  logic                      readAck,
    input  logic                      writeAck,
    input  logic                      readLineValid,
    input  logic                      writeDone,
    output logic                      readReq,
    output logic                      writeReq,
    output MemoryBurstPkg::wordAddr_t readAddr,
    output MemoryBurstPkg::wordAddr_t writeAddr,
    output logic                      busy
);

    logic readPending;                      // taken, line not yet returned
    logic writePending;                     // taken, last beat not yet sent
    logic readActive;                       // acked by the sdram
    logic writeActive;

    logic readTaken;
    logic writeTaken;

    MemoryBurstPkg::lineAddr_t readLineHeld;
    MemoryBurstPkg::lineAddr_t writeLineHeld;

    assign busy       = readPending || writePending;
    assign readTaken  = readLineReq && !busy;
    assign writeTaken = writeLineReq && !busy;

    // read wins, write waits until the read line is back
    assign readReq  = readPending && !readActive && !writeActive;
    assign writeReq = writePending && !writeActive && !readPending;

    assign readAddr  = {readLineHeld, MemoryBurstPkg::BankWidth'(0)};
    assign writeAddr = {writeLineHeld, MemoryBurstPkg::BankWidth'(0)};

    always_ff @(posedge clk) begin
        if (rst) begin
            readPending  <= 1'b0;
            writePending <= 1'b0;
            readActive   <= 1'b0;
            writeActive  <= 1'b0;
        end else begin
            if (readTaken) begin
                readPending <= 1'b1;
            end else if (readLineValid) begin
                readPending <= 1'b0;
            end
            if (writeTaken) begin
                writePending <= 1'b1;
            end else if (writeDone) begin
                writePending <= 1'b0;
            end
            if (readAck) begin
                readActive <= 1'b1;
            end else if (readLineValid) begin
                readActive <= 1'b0;
            end
            if (writeAck) begin
                writeActive <= 1'b1;
            end else if (writeDone) begin
                writeActive <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readTaken) begin
            readLineHeld <= readLineAddr;
        end
        if (writeTaken) begin
            writeLineHeld <= writeLineAddr;
        end
    end

    // the requester has to wait for busy to fall
    noRequestWhileBusy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !(readLineReq || writeLineReq));

    // sdram request levels stay up until acknowledged
    readReqHeld: assert property (@(posedge clk) disable iff (rst)
        (readReq && !readAck) |=> readReq);

endmodule

// File: source/WriteLineSerializer.sv
// Write line serializer
// Holds the line of a write request and hands it to the SDRAM one word
// per write beat, then signals the end of the burst.

`timescale 1ns/10ps

module WriteLineSerializer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  writeLineReq,
    input  MemoryBurstPkg::line_t writeLine,
    input  logic                  writeDataEnable,
    output MemoryBurstPkg::word_t writeData,
    output logic                  writeDone
);

    MemoryBurstPkg::line_t lineHeld;
    logic [MemoryBurstPkg::BankWidth-1:0] beatCount;
    logic lastBeat;

    assign lastBeat = (beatCount == MemoryBurstPkg::BankWidth'(MemoryBurstPkg::LineWords - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            beatCount <= '0;
            writeDone <= 1'b0;
        end else begin
            writeDone <= writeDataEnable && lastBeat;    // one cycle after the eighth beat
            if (writeDataEnable) begin
                beatCount <= beatCount + 1'b1;           // wraps back to zero
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeLineReq) begin
            lineHeld <= writeLine;
        end
        // word k lands in the cycle the array writes bank k
        if (writeDataEnable) begin
            writeData <= lineHeld[beatCount];
        end
    end

    // a new line must not replace one that is being sent
    noLoadDuringBurst: assert property (@(posedge clk) disable iff (rst)
        writeLineReq |-> (beatCount == '0));

endmodule

// File: source/InternalSdram.sv
// Internal SDRAM model
// Serves fixed 8-beat read and write bursts on an interleaved word array
// with a registered read port. A small sequencer counts the burst cycles
// and gives reads priority when both requests wait.

`timescale 1ns/10ps

module InternalSdram (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      readReq,
    input  logic                      writeReq,
    input  MemoryBurstPkg::wordAddr_t readAddr,
    input  MemoryBurstPkg::wordAddr_t writeAddr,
    input  MemoryBurstPkg::word_t     writeData,
    output logic                      readAck,
    output logic                      writeAck,
    output logic                      readDataEnable,
    output logic                      writeDataEnable,
    output MemoryBurstPkg::word_t     readData
);

    typedef enum logic [1:0] {
        StateIdle  = 2'd0,
        StateRead  = 2'd1,
        StateWrite = 2'd2
    } sdramState_t;

    typedef logic [MemoryBurstPkg::SdramCycleWidth-1:0] cycle_t;
    typedef logic [MemoryBurstPkg::BankWidth-1:0] bank_t;

    sdramState_t state;
    sdramState_t nextState;
    cycle_t      cycle;
    cycle_t      nextCycle;

    bank_t                     bank;
    MemoryBurstPkg::wordAddr_t arrayIndex;
    logic                      arrayWrite;
    MemoryBurstPkg::word_t     arrayReadValue;

    MemoryBurstPkg::word_t body [2**MemoryBurstPkg::WordAddrWidth];

    // single port, read data one cycle after the index
    always_ff @(posedge clk) begin
        arrayReadValue <= body[arrayIndex];
        if (arrayWrite) begin
            body[arrayIndex] <= writeData;
        end
    end

    assign readData = arrayReadValue;

    assign readAck  = (state == StateRead) && (cycle == '0);
    assign writeAck = (state == StateWrite) && (cycle == '0);

    assign readDataEnable = (state == StateRead)
        && (cycle >= cycle_t'(MemoryBurstPkg::SdramReadEnableCycle))
        && (cycle < cycle_t'(MemoryBurstPkg::SdramReadDisableCycle));

    assign writeDataEnable = (state == StateWrite)
        && (cycle >= cycle_t'(MemoryBurstPkg::SdramWriteEnableCycle))
        && (cycle < cycle_t'(MemoryBurstPkg::SdramWriteDisableCycle));

    assign arrayWrite = (state == StateWrite)
        && (cycle >= cycle_t'(MemoryBurstPkg::SdramWriteStartCycle))
        && (cycle < cycle_t'(MemoryBurstPkg::SdramWriteEndCycle));

    // bank follows the cycle, wraps harmlessly outside the data window
    always_comb begin
        case (state)
            StateRead: begin
                bank = bank_t'(cycle - cycle_t'(MemoryBurstPkg::SdramReadStartCycle));
                arrayIndex = {readAddr[MemoryBurstPkg::WordAddrWidth-1:MemoryBurstPkg::BankWidth],
                              bank};
            end
            StateWrite: begin
                bank = bank_t'(cycle - cycle_t'(MemoryBurstPkg::SdramWriteStartCycle));
                arrayIndex = {writeAddr[MemoryBurstPkg::WordAddrWidth-1:MemoryBurstPkg::BankWidth],
                              bank};
            end
            default: begin
                bank       = '0;
                arrayIndex = '0;
            end
        endcase
    end

    always_comb begin
        nextState = state;
        nextCycle = cycle + 1'b1;
        case (state)
            StateRead: begin
                if (cycle == cycle_t'(MemoryBurstPkg::SdramReadEndCycle)) begin
                    nextState = StateIdle;
                    nextCycle = '0;
                end
            end
            StateWrite: begin
                if (cycle == cycle_t'(MemoryBurstPkg::SdramWriteEndCycle)) begin
                    nextState = StateIdle;
                    nextCycle = '0;
                end
            end
            default: begin
                nextCycle = '0;
                if (readReq) begin             // read priority
                    nextState = StateRead;
                end else if (writeReq) begin
                    nextState = StateWrite;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
            cycle <= '0;
        end else begin
            state <= nextState;
            cycle <= nextCycle;
        end
    end

    ackExclusive: assert property (@(posedge clk) disable iff (rst)
        !(readAck && writeAck));

endmodule

// File: source/ReadLineAssembler.sv
// Read line assembler
// Collects the eight beats of a read burst into one line and flags the
// line for a single cycle once the last word is in.

`timescale 1ns/10ps

module ReadLineAssembler (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  readDataEnable,
    input  MemoryBurstPkg::word_t readData,
    output MemoryBurstPkg::line_t readLine,
    output logic                  readLineValid
);

    logic [MemoryBurstPkg::BankWidth-1:0] beatCount;
    logic lastBeat;

    assign lastBeat = (beatCount == MemoryBurstPkg::BankWidth'(MemoryBurstPkg::LineWords - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            beatCount     <= '0;
            readLineValid <= 1'b0;
        end else begin
            readLineValid <= readDataEnable && lastBeat;    // cycle after beat 8
            if (readDataEnable) begin
                beatCount <= beatCount + 1'b1;
            end
        end
    end

    // beat k goes to slot k, line held until the next burst
    always_ff @(posedge clk) begin
        if (readDataEnable) begin
            readLine[beatCount] <= readData;
        end
    end

endmodule

// File: source/MemoryBurstTop.sv
// Memory burst port top level
// Joins the request arbiter, the write serializer, the SDRAM model and
// the read assembler into one line-wide memory port.

`timescale 1ns/10ps

module MemoryBurstTop (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      readLineReq,
    input  MemoryBurstPkg::lineAddr_t readLineAddr,
    input  logic                      writeLineReq,
    input  MemoryBurstPkg::lineAddr_t writeLineAddr,
    input  MemoryBurstPkg::line_t     writeLine,
    output logic                      busy,
    output MemoryBurstPkg::line_t     readLine,
    output logic                      readLineValid
);

    logic                      readReq;
    logic                      writeReq;
    logic                      readAck;
    logic                      writeAck;
    MemoryBurstPkg::wordAddr_t readAddr;
    MemoryBurstPkg::wordAddr_t writeAddr;
    logic                      readDataEnable;
    logic                      writeDataEnable;
    MemoryBurstPkg::word_t     readData;
    MemoryBurstPkg::word_t     writeData;
    logic                      writeDone;

    BurstRequestArbiter i_BurstRequestArbiter (
        .clk           (clk),
        .rst           (rst),
        .readLineReq   (readLineReq),
        .readLineAddr  (readLineAddr),
        .writeLineReq  (writeLineReq),
        .writeLineAddr (writeLineAddr),
        .readAck       (readAck),
        .writeAck      (writeAck),
        .readLineValid (readLineValid),
        .writeDone     (writeDone),
        .readReq       (readReq),
        .writeReq      (writeReq),
        .readAddr      (readAddr),
        .writeAddr     (writeAddr),
        .busy          (busy)
    );

    WriteLineSerializer i_WriteLineSerializer (
        .clk             (clk),
        .rst             (rst),
        .writeLineReq    (writeLineReq),
        .writeLine       (writeLine),
        .writeDataEnable (writeDataEnable),
        .writeData       (writeData),
        .writeDone       (writeDone)
    );

    InternalSdram i_InternalSdram (
        .clk             (clk),
        .rst             (rst),
        .readReq         (readReq),
        .writeReq        (writeReq),
        .readAddr        (readAddr),
        .writeAddr       (writeAddr),
        .writeData       (writeData),
        .readAck         (readAck),
        .writeAck        (writeAck),
        .readDataEnable  (readDataEnable),
        .writeDataEnable (writeDataEnable),
        .readData        (readData)
    );

    ReadLineAssembler i_ReadLineAssembler (
        .clk            (clk),
        .rst            (rst),
        .readDataEnable (readDataEnable),
        .readData       (readData),
        .readLine       (readLine),
        .readLineValid  (readLineValid)
    );

endmodule

// File: verification/LineMemoryModel.sv
// Line memory reference model
// Keeps the expected contents of every line address and which lines
// have been written, for the memory burst port testbench.

`timescale 1ns/10ps

module LineMemoryModel;

    localparam int LineCount = 2**MemoryBurstPkg::LineAddrWidth;

    MemoryBurstPkg::line_t lines [LineCount];
    logic                  written [LineCount];

    initial begin
        for (int i = 0; i < LineCount; i++) begin
            written[i] = 1'b0;
            lines[i]   = '0;
        end
    end

    task automatic storeLine(input MemoryBurstPkg::lineAddr_t addr,
                             input MemoryBurstPkg::line_t line);
        lines[addr]   = line;
        written[addr] = 1'b1;
    endtask

    function automatic MemoryBurstPkg::line_t fetchLine(input MemoryBurstPkg::lineAddr_t addr);
        return lines[addr];
    endfunction

    function automatic logic isWritten(input MemoryBurstPkg::lineAddr_t addr);
        return written[addr];
    endfunction

endmodule

// File: verification/MemoryBurstTb.sv
// Memory burst port testbench
// Drives line reads and writes from an xorshift stream, checks each
// returned line and the busy flag against a line model, and reports
// one line per test plus a closing count.

`timescale 1ns/10ps

module MemoryBurstTb;

    localparam int TotalOps        = 220;
    localparam int OpTimeoutCycles = 40;
    localparam int WatchdogCycles  = TotalOps * 40 + 100;

    logic                      clk;
    logic                      rst;
    logic                      readLineReq;
    MemoryBurstPkg::lineAddr_t readLineAddr;
    logic                      writeLineReq;
    MemoryBurstPkg::lineAddr_t writeLineAddr;
    MemoryBurstPkg::line_t     writeLine;
    logic                      busy;
    MemoryBurstPkg::line_t     readLine;
    logic                      readLineValid;

    logic [31:0] rngState;
    int          errorCount;
    int          testErrorsAtStart;
    int          testIndex;
    int          passCount;

    MemoryBurstTop i_MemoryBurstTop (
        .clk           (clk),
        .rst           (rst),
        .readLineReq   (readLineReq),
        .readLineAddr  (readLineAddr),
        .writeLineReq  (writeLineReq),
        .writeLineAddr (writeLineAddr),
        .writeLine     (writeLine),
        .busy          (busy),
        .readLine      (readLine),
        .readLineValid (readLineValid)
    );

    LineMemoryModel i_LineMemoryModel ();

    always #10 clk = ~clk;                          // 20 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic MemoryBurstPkg::line_t randomLine();
        MemoryBurstPkg::line_t line;
        for (int k = 0; k < MemoryBurstPkg::LineWords; k++) begin
            line[k] = nextRandom();
        end
        return line;
    endfunction

    task automatic checkLine(input string name, input MemoryBurstPkg::line_t got,
                             input MemoryBurstPkg::line_t expected);
        if (got !== expected) begin
            errorCount++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic checkBusy(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            errorCount++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // one request cycle, then follow the port until busy drops
    task automatic runOp(input logic doRead, input MemoryBurstPkg::lineAddr_t rAddr,
                         input logic doWrite, input MemoryBurstPkg::lineAddr_t wAddr,
                         input MemoryBurstPkg::line_t wLine,
                         input MemoryBurstPkg::line_t expected);
        int                    pulses;
        int                    waited;
        MemoryBurstPkg::line_t gotLine;
        pulses  = 0;
        waited  = 0;
        gotLine = '0;
        checkBusy("busy", busy, 1'b0);              // port idle before issuing
        @(posedge clk);
        readLineReq   <= doRead;
        readLineAddr  <= rAddr;
        writeLineReq  <= doWrite;
        writeLineAddr <= wAddr;
        writeLine     <= wLine;
        @(posedge clk);                             // request taken here
        readLineReq  <= 1'b0;
        writeLineReq <= 1'b0;
        @(negedge clk);
        checkBusy("busy", busy, 1'b1);
        while (busy && waited < OpTimeoutCycles) begin
            if (readLineValid) begin
                pulses++;
                gotLine = readLine;
            end
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            errorCount++;
            $display("busy stayed high for %0d cycles after a request", OpTimeoutCycles);
        end
        if (pulses != (doRead ? 1 : 0)) begin
            errorCount++;
            $display("saw %0d readLineValid pulses for one operation", pulses);
        end
        if (doRead && pulses == 1) begin
            checkLine("readLine", gotLine, expected);
        end
    endtask

    task automatic writeOp(input MemoryBurstPkg::lineAddr_t addr,
                           input MemoryBurstPkg::line_t line);
        runOp(1'b0, '0, 1'b1, addr, line, '0);
        i_LineMemoryModel.storeLine(addr, line);
    endtask

    task automatic readOp(input MemoryBurstPkg::lineAddr_t addr);
        runOp(1'b1, addr, 1'b0, '0, '0, i_LineMemoryModel.fetchLine(addr));
    endtask

    task automatic startTest();
        testErrorsAtStart = errorCount;
        testIndex++;
    endtask

    task automatic finishTest(input string name);
        if (errorCount == testErrorsAtStart) begin
            passCount++;
            $display("test %0d %s: ok", testIndex, name);
        end else begin
            $display("test %0d %s: FAILED", testIndex, name);
        end
    endtask

    // watchdog
    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WatchdogCycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        MemoryBurstPkg::lineAddr_t addrA;
        MemoryBurstPkg::lineAddr_t addrB;
        MemoryBurstPkg::lineAddr_t wAddr;
        MemoryBurstPkg::line_t     oldLine;
        MemoryBurstPkg::line_t     newLine;
        logic [31:0]               pick;
        clk           = 1'b0;
        rst           = 1'b1;
        readLineReq   = 1'b0;
        readLineAddr  = '0;
        writeLineReq  = 1'b0;
        writeLineAddr = '0;
        writeLine     = '0;
        rngState      = 32'h92ef;
        errorCount    = 0;
        testIndex     = 0;
        passCount     = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        startTest();
        repeat (10) begin
            @(negedge clk);
            checkBusy("busy", busy, 1'b0);
            checkBusy("readLineValid", readLineValid, 1'b0);
        end
        finishTest("idle after reset");

        startTest();
        addrA = MemoryBurstPkg::lineAddr_t'(nextRandom());
        writeOp(addrA, randomLine());
        readOp(addrA);
        finishTest("write then read");

        // read sees the old line, the write lands afterwards
        startTest();
        oldLine = i_LineMemoryModel.fetchLine(addrA);
        newLine = randomLine();
        runOp(1'b1, addrA, 1'b1, addrA, newLine, oldLine);
        i_LineMemoryModel.storeLine(addrA, newLine);
        readOp(addrA);
        finishTest("read and write together");

        startTest();
        addrB = addrA + 1'b1;                       // neighbor line
        writeOp(addrB, randomLine());
        writeOp(addrA, randomLine());
        readOp(addrB);
        readOp(addrA);
        finishTest("overwrite keeps neighbor");

        startTest();
        for (int i = 0; i < 200; i++) begin
            pick  = nextRandom();
            addrA = MemoryBurstPkg::lineAddr_t'(nextRandom());
            if (pick[0] && i_LineMemoryModel.isWritten(addrA)) begin
                if (pick[1]) begin                  // read plus write in one cycle
                    wAddr   = MemoryBurstPkg::lineAddr_t'(nextRandom());
                    newLine = randomLine();
                    runOp(1'b1, addrA, 1'b1, wAddr, newLine,
                          i_LineMemoryModel.fetchLine(addrA));
                    i_LineMemoryModel.storeLine(wAddr, newLine);
                end else begin
                    readOp(addrA);
                end
            end else begin
                writeOp(addrA, randomLine());
            end
        end
        finishTest("random traffic");

        // each op starts on the first edge after busy falls
        startTest();
        addrA = MemoryBurstPkg::lineAddr_t'(nextRandom());
        for (int i = 0; i < 5; i++) begin
            writeOp(addrA, randomLine());
            readOp(addrA);
        end
        finishTest("busy back to back");

        $display("passed %0d of %0d tests, %0d check errors", passCount, testIndex, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: MemoryBurst.f
source/MemoryBurstPkg.sv
source/BurstRequestArbiter.sv
source/WriteLineSerializer.sv
source/InternalSdram.sv
source/ReadLineAssembler.sv
source/MemoryBurstTop.sv
verification/LineMemoryModel.sv
verification/MemoryBurstTb.sv
